// ==== src/pcs_tx_cfg.svh ====
`ifndef PCS_TX_CFG_SVH
`define PCS_TX_CFG_SVH

`define PCS_NB_DATA    64
`define PCS_NB_CTRL    8
`define PCS_NB_BLOCK   66
`define PCS_NB_ERRCNT  32

`define PCS_SYNC_DATA  2'b01
`define PCS_SYNC_CTRL  2'b10

// Block type field values
`define PCS_BT_IDLE    8'h1E
`define PCS_BT_START   8'h78
`define PCS_BT_TERM0   8'h87
`define PCS_BT_TERM1   8'h99
`define PCS_BT_TERM2   8'hAA
`define PCS_BT_TERM3   8'hB4
`define PCS_BT_TERM4   8'hCC
`define PCS_BT_TERM5   8'hD2
`define PCS_BT_TERM6   8'hE1
`define PCS_BT_TERM7   8'hFF

`define PCS_XG_IDLE    8'h07
`define PCS_XG_START   8'hFB
`define PCS_XG_TERM    8'hFD
`define PCS_XG_ERROR   8'hFE

`define PCS_CC_IDLE    7'h00
`define PCS_CC_ERROR   7'h1E

`define PCS_REG_CTRL   1'b0
`define PCS_REG_ERRCNT 1'b1

`endif

// ==== src/pcs_tx_pkg.sv ====
`include "pcs_tx_cfg.svh"

package pcs_tx_pkg;

  typedef struct packed {
    logic [`PCS_NB_DATA-1:0] data;
    logic [`PCS_NB_CTRL-1:0] ctrl; // Bit i flags byte i
  } xgmii_word_t;

  typedef struct packed {
    logic [`PCS_NB_DATA-1:0] payload;
    logic [1:0]              sync;
  } data_view_t;

  typedef struct packed {
    logic [`PCS_NB_DATA-9:0] payload; // Lane 0 in the low bits
    logic [7:0]              btype;
    logic [1:0]              sync;
  } ctrl_view_t;

  // Same 66 bits, read as data or control block
  typedef union packed {
    data_view_t data_view;
    ctrl_view_t ctrl_view;
  } block_t;

  typedef enum logic [2:0] {
    KIND_C,
    KIND_S,
    KIND_D,
    KIND_T,
    KIND_E
  } block_kind_t;

  typedef struct packed {
    block_t      block;
    block_kind_t kind;
  } coded_beat_t;

  // Control block carrying eight error codes
  function automatic block_t error_block();
    block_t blk;
    blk.ctrl_view.sync    = `PCS_SYNC_CTRL;
    blk.ctrl_view.btype   = `PCS_BT_IDLE;
    blk.ctrl_view.payload = {8{`PCS_CC_ERROR}};
    return blk;
  endfunction

endpackage

// ==== src/pcs_tx_block_encoder.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx_block_encoder
(
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_enable,
  input  pcs_tx_pkg::xgmii_word_t  i_xg,
  input  logic                     i_xg_valid,
  output logic                     o_xg_ready,
  output pcs_tx_pkg::coded_beat_t  o_beat,
  output logic                     o_beat_valid,
  input  logic                     i_beat_ready
);

  logic                    is_data;
  logic                    is_idle;
  logic                    is_start;
  logic                    term_hit;
  logic [2:0]              term_lane;
  logic                    xg_take;
  pcs_tx_pkg::coded_beat_t beat_next;

  // Lanes below k data, lane k terminate, lanes above idle
  function automatic logic term_at(input pcs_tx_pkg::xgmii_word_t xg, input int k);
    logic ok;
    ok = xg.ctrl[k] && (xg.data[8*k +: 8] == `PCS_XG_TERM);
    for (int j = 0; j < `PCS_NB_CTRL; j++)
    begin
      if (j < k)
        ok = ok && !xg.ctrl[j];
      else if (j > k)
        ok = ok && xg.ctrl[j] && (xg.data[8*j +: 8] == `PCS_XG_IDLE);
    end
    return ok;
  endfunction

  function automatic logic [7:0] term_type(input logic [2:0] lane);
    case (lane)
      3'd0: term_type = `PCS_BT_TERM0;
      3'd1: term_type = `PCS_BT_TERM1;
      3'd2: term_type = `PCS_BT_TERM2;
      3'd3: term_type = `PCS_BT_TERM3;
      3'd4: term_type = `PCS_BT_TERM4;
      3'd5: term_type = `PCS_BT_TERM5;
      3'd6: term_type = `PCS_BT_TERM6;
      default: term_type = `PCS_BT_TERM7;
    endcase
  endfunction

  assign is_data  = (i_xg.ctrl == 8'h00);
  assign is_idle  = (i_xg.ctrl == 8'hFF) && (i_xg.data == {8{`PCS_XG_IDLE}});
  assign is_start = (i_xg.ctrl == 8'h01) && (i_xg.data[7:0] == `PCS_XG_START);

  always_comb
  begin
    term_hit  = 1'b0;
    term_lane = 3'd0;
    for (int k = 0; k < `PCS_NB_CTRL; k++)
    begin
      if (term_at(i_xg, k))
      begin
        term_hit  = 1'b1;
        term_lane = 3'(k);
      end
    end
  end

  always_comb
  begin
    beat_next.block = '0;
    beat_next.kind  = pcs_tx_pkg::KIND_E;
    if (is_data)
    begin
      beat_next.kind                    = pcs_tx_pkg::KIND_D;
      beat_next.block.data_view.sync    = `PCS_SYNC_DATA;
      beat_next.block.data_view.payload = i_xg.data;
    end
    else if (is_idle)
    begin
      beat_next.kind                    = pcs_tx_pkg::KIND_C;
      beat_next.block.ctrl_view.sync    = `PCS_SYNC_CTRL;
      beat_next.block.ctrl_view.btype   = `PCS_BT_IDLE;
      beat_next.block.ctrl_view.payload = {8{`PCS_CC_IDLE}};
    end
    else if (is_start)
    begin
      beat_next.kind                    = pcs_tx_pkg::KIND_S;
      beat_next.block.ctrl_view.sync    = `PCS_SYNC_CTRL;
      beat_next.block.ctrl_view.btype   = `PCS_BT_START;
      beat_next.block.ctrl_view.payload = i_xg.data[63:8]; // Bytes 1 to 7
    end
    else if (term_hit)
    begin
      beat_next.kind                  = pcs_tx_pkg::KIND_T;
      beat_next.block.ctrl_view.sync  = `PCS_SYNC_CTRL;
      beat_next.block.ctrl_view.btype = term_type(term_lane);
      for (int j = 0; j < 7; j++)
        if (j < term_lane)
          beat_next.block.ctrl_view.payload[8*j +: 8] = i_xg.data[8*j +: 8];
    end
    else
      beat_next.block = pcs_tx_pkg::error_block();
  end

  assign o_xg_ready = i_enable && (!o_beat_valid || i_beat_ready);
  assign xg_take    = i_xg_valid && o_xg_ready;

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      o_beat_valid <= 1'b0;
    else if (xg_take)
      o_beat_valid <= 1'b1;
    else if (i_beat_ready)
      o_beat_valid <= 1'b0;
  end

  always_ff @(posedge i_clock)
  begin
    if (xg_take)
      o_beat <= beat_next;
  end

  // Stalled beat must not change under the checker
  a_stall_stable: assert property (@(posedge i_clock) disable iff (i_reset)
    o_beat_valid && !i_beat_ready |=> o_beat_valid && $stable(o_beat));

endmodule

// ==== src/pcs_tx_sequence_check.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx_sequence_check
(
  input  logic                       i_clock,
  input  logic                       i_reset,
  input  pcs_tx_pkg::coded_beat_t    i_beat,
  input  logic                       i_beat_valid,
  output logic                       o_beat_ready,
  output pcs_tx_pkg::block_t         o_block,
  output logic                       o_block_valid,
  input  logic                       i_block_ready,
  input  logic                       i_errcnt_clear,
  output logic [`PCS_NB_ERRCNT-1:0]  o_errcnt
);

  localparam logic [4:0] ST_INIT = 5'b10000;
  localparam logic [4:0] ST_C    = 5'b01000;
  localparam logic [4:0] ST_D    = 5'b00100;
  localparam logic [4:0] ST_T    = 5'b00010;
  localparam logic [4:0] ST_E    = 5'b00001;

  logic [4:0] state;
  logic [4:0] state_next;
  logic       to_error;
  logic       beat_take;

  always_comb
  begin
    state_next = ST_E;
    case (state)
      ST_INIT, ST_C, ST_T:
      begin
        if (i_beat.kind == pcs_tx_pkg::KIND_C)
          state_next = ST_C;
        else if (i_beat.kind == pcs_tx_pkg::KIND_S)
          state_next = ST_D;
      end
      ST_D:
      begin
        if (i_beat.kind == pcs_tx_pkg::KIND_D)
          state_next = ST_D;
        else if (i_beat.kind == pcs_tx_pkg::KIND_T)
          state_next = ST_T;
      end
      default: // ST_E where a start stays an error
      begin
        if (i_beat.kind == pcs_tx_pkg::KIND_T)
          state_next = ST_T;
        else if (i_beat.kind == pcs_tx_pkg::KIND_D)
          state_next = ST_D;
        else if (i_beat.kind == pcs_tx_pkg::KIND_C)
          state_next = ST_C;
      end
    endcase
  end

  assign to_error     = (state_next == ST_E);
  assign o_beat_ready = !o_block_valid || i_block_ready;
  assign beat_take    = i_beat_valid && o_beat_ready;

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      state         <= ST_INIT;
      o_block_valid <= 1'b0;
    end
    else if (beat_take)
    begin
      state         <= state_next;
      o_block_valid <= 1'b1;
    end
    else if (i_block_ready)
      o_block_valid <= 1'b0;
  end

  always_ff @(posedge i_clock)
  begin
    if (beat_take)
      o_block <= to_error ? pcs_tx_pkg::error_block() : i_beat.block;
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset || i_errcnt_clear)
      o_errcnt <= '0;
    else if (beat_take && to_error && !(&o_errcnt)) // Saturates
      o_errcnt <= o_errcnt + 1'b1;
  end

  a_state_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
    $onehot(state));

endmodule

// ==== src/pcs_tx_scrambler.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx_scrambler
(
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_bypass,
  input  pcs_tx_pkg::block_t  i_block,
  input  logic                i_block_valid,
  output logic                o_block_ready,
  output pcs_tx_pkg::block_t  o_block,
  output logic                o_block_valid,
  input  logic                i_block_ready
);

  logic [57:0]        scr_state;
  logic [57:0]        state_next;
  logic               scr_bit;
  logic               block_take;
  pcs_tx_pkg::block_t scr_block;

  // x^58 + x^39 + 1 with payload bit 0 first
  always_comb
  begin
    scr_block  = i_block;
    state_next = scr_state;
    scr_bit    = 1'b0;
    for (int i = 0; i < `PCS_NB_DATA; i++)
    begin
      scr_bit = i_block.data_view.payload[i] ^ state_next[38] ^ state_next[57];
      scr_block.data_view.payload[i] = scr_bit;
      state_next = {state_next[56:0], scr_bit};
    end
  end

  assign o_block_ready = !o_block_valid || i_block_ready;
  assign block_take    = i_block_valid && o_block_ready;

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      scr_state     <= '1;
      o_block_valid <= 1'b0;
    end
    else if (block_take)
    begin
      if (!i_bypass)
        scr_state <= state_next;
      o_block_valid <= 1'b1;
    end
    else if (i_block_ready)
      o_block_valid <= 1'b0;
  end

  always_ff @(posedge i_clock)
  begin
    if (block_take)
      o_block <= i_bypass ? i_block : scr_block;
  end

  a_sync_legal: assert property (@(posedge i_clock) disable iff (i_reset)
    o_block_valid |-> (o_block.data_view.sync == `PCS_SYNC_DATA ||
                       o_block.data_view.sync == `PCS_SYNC_CTRL));

endmodule

// ==== src/pcs_tx_regs.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx_regs
(
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_reg_wr,
  input  logic                      i_reg_rd,
  input  logic                      i_reg_addr,
  input  logic [31:0]               i_reg_wdata,
  output logic [31:0]               o_reg_rdata,
  input  logic [`PCS_NB_ERRCNT-1:0] i_errcnt,
  output logic                      o_enable,
  output logic                      o_bypass,
  output logic                      o_errcnt_clear
);

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      o_enable       <= 1'b0;
      o_bypass       <= 1'b0;
      o_errcnt_clear <= 1'b0;
    end
    else
    begin
      o_errcnt_clear <= i_reg_wr && (i_reg_addr == `PCS_REG_ERRCNT); // One cycle pulse
      if (i_reg_wr && (i_reg_addr == `PCS_REG_CTRL))
      begin
        o_enable <= i_reg_wdata[0];
        o_bypass <= i_reg_wdata[1];
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      o_reg_rdata <= '0;
    else if (i_reg_rd)
    begin
      if (i_reg_addr == `PCS_REG_CTRL)
        o_reg_rdata <= {30'd0, o_bypass, o_enable};
      else
        o_reg_rdata <= i_errcnt; // Live counter value
    end
  end

endmodule

// ==== src/pcs_tx.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx
(
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  pcs_tx_pkg::xgmii_word_t  i_xg,
  input  logic                     i_xg_valid,
  output logic                     o_xg_ready,
  output pcs_tx_pkg::block_t       o_block,
  output logic                     o_block_valid,
  input  logic                     i_block_ready,
  input  logic                     i_reg_wr,
  input  logic                     i_reg_rd,
  input  logic                     i_reg_addr,
  input  logic [31:0]              i_reg_wdata,
  output logic [31:0]              o_reg_rdata
);

  logic                      enable;
  logic                      bypass;
  logic                      errcnt_clear;
  logic [`PCS_NB_ERRCNT-1:0] errcnt;

  pcs_tx_pkg::coded_beat_t   beat;
  logic                      beat_valid;
  logic                      beat_ready;
  pcs_tx_pkg::block_t        chk_block;
  logic                      chk_valid;
  logic                      chk_ready;

  pcs_tx_block_encoder u_encoder
  (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_enable     (enable),
    .i_xg         (i_xg),
    .i_xg_valid   (i_xg_valid),
    .o_xg_ready   (o_xg_ready),
    .o_beat       (beat),
    .o_beat_valid (beat_valid),
    .i_beat_ready (beat_ready)
  );

  pcs_tx_sequence_check u_check
  (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_beat         (beat),
    .i_beat_valid   (beat_valid),
    .o_beat_ready   (beat_ready),
    .o_block        (chk_block),
    .o_block_valid  (chk_valid),
    .i_block_ready  (chk_ready),
    .i_errcnt_clear (errcnt_clear),
    .o_errcnt       (errcnt)
  );

  pcs_tx_scrambler u_scrambler
  (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_bypass      (bypass),
    .i_block       (chk_block),
    .i_block_valid (chk_valid),
    .o_block_ready (chk_ready),
    .o_block       (o_block),
    .o_block_valid (o_block_valid),
    .i_block_ready (i_block_ready)
  );

  pcs_tx_regs u_regs
  (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_reg_wr       (i_reg_wr),
    .i_reg_rd       (i_reg_rd),
    .i_reg_addr     (i_reg_addr),
    .i_reg_wdata    (i_reg_wdata),
    .o_reg_rdata    (o_reg_rdata),
    .i_errcnt       (errcnt),
    .o_enable       (enable),
    .o_bypass       (bypass),
    .o_errcnt_clear (errcnt_clear)
  );

endmodule

// ==== bench/pcs_tx_tb.sv ====
`include "pcs_tx_cfg.svh"

module pcs_tx_tb;

  localparam int CLK_PERIOD = 20;
  localparam int N_WORDS    = 42 + 42 + 12 + 16 * 5;
  localparam logic [63:0] TERM_CODES = 64'hFFE1D2CCB4AA9987; // Lane k in byte k
  localparam logic [65:0] ERR_BLOCK  = {{8{`PCS_CC_ERROR}}, `PCS_BT_IDLE, `PCS_SYNC_CTRL};
  localparam int ST_INIT = 0;
  localparam int ST_C    = 1;
  localparam int ST_D    = 2;
  localparam int ST_T    = 3;
  localparam int ST_E    = 4;

  logic                    i_clock;
  logic                    i_reset;
  pcs_tx_pkg::xgmii_word_t i_xg;
  logic                    i_xg_valid;
  logic                    o_xg_ready;
  pcs_tx_pkg::block_t      o_block;
  logic                    o_block_valid;
  logic                    i_block_ready = 1'b1;
  logic                    i_reg_wr;
  logic                    i_reg_rd;
  logic                    i_reg_addr;
  logic [31:0]             i_reg_wdata;
  logic [31:0]             o_reg_rdata;

  integer                  seed = 32'hd11e;
  logic [65:0]             exp_q[$];
  int                      seq_state = ST_INIT;
  int                      exp_errcnt = 0;
  logic [57:0]             scr_state = '1;
  logic                    cur_bypass = 1'b0;
  int                      accepted_count = 0;
  int                      sent_count = 0;
  int                      out_count = 0;
  logic                    gaps_on = 1'b0;
  logic                    ready_random = 1'b0;
  pcs_tx_pkg::block_kind_t ref_kind;
  logic [65:0]             ref_blk;
  logic [65:0]             exp_blk;
  logic [31:0]             rdata;

  pcs_tx u_dut
  (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_xg          (i_xg),
    .i_xg_valid    (i_xg_valid),
    .o_xg_ready    (o_xg_ready),
    .o_block       (o_block),
    .o_block_valid (o_block_valid),
    .i_block_ready (i_block_ready),
    .i_reg_wr      (i_reg_wr),
    .i_reg_rd      (i_reg_rd),
    .i_reg_addr    (i_reg_addr),
    .i_reg_wdata   (i_reg_wdata),
    .o_reg_rdata   (o_reg_rdata)
  );

  initial
  begin
    i_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
  end

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input logic [65:0] actual, input logic [65:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Encoding rules with lane patterns tested as whole ctrl masks
  function automatic pcs_tx_pkg::block_kind_t encode_ref(input pcs_tx_pkg::xgmii_word_t xg,
                                                         output logic [65:0] blk);
    logic [55:0] keep;
    logic [7:0]  mask;
    logic        tail_idle;
    if (xg.ctrl == 8'h00)
    begin
      blk = {xg.data, `PCS_SYNC_DATA};
      return pcs_tx_pkg::KIND_D;
    end
    if (xg.ctrl == 8'hFF && xg.data == {8{`PCS_XG_IDLE}})
    begin
      blk = {56'd0, `PCS_BT_IDLE, `PCS_SYNC_CTRL};
      return pcs_tx_pkg::KIND_C;
    end
    if (xg.ctrl == 8'h01 && xg.data[7:0] == `PCS_XG_START)
    begin
      blk = {xg.data[63:8], `PCS_BT_START, `PCS_SYNC_CTRL};
      return pcs_tx_pkg::KIND_S;
    end
    for (int k = 0; k < 8; k++)
    begin
      mask      = 8'hFF << k;
      tail_idle = 1'b1;
      for (int j = k + 1; j < 8; j++)
        tail_idle = tail_idle && (xg.data[8*j +: 8] == `PCS_XG_IDLE);
      if (xg.ctrl == mask && xg.data[8*k +: 8] == `PCS_XG_TERM && tail_idle)
      begin
        keep = (56'd1 << (8 * k)) - 56'd1; // Data bytes below the terminate lane
        blk  = {xg.data[55:0] & keep, TERM_CODES[8*k +: 8], `PCS_SYNC_CTRL};
        return pcs_tx_pkg::KIND_T;
      end
    end
    blk = ERR_BLOCK;
    return pcs_tx_pkg::KIND_E;
  endfunction

  function automatic logic [65:0] check_ref(input pcs_tx_pkg::block_kind_t kind,
                                            input logic [65:0] blk);
    int next;
    next = ST_E;
    if (seq_state == ST_D)
    begin
      if (kind == pcs_tx_pkg::KIND_D)
        next = ST_D;
      else if (kind == pcs_tx_pkg::KIND_T)
        next = ST_T;
    end
    else if (seq_state == ST_E)
    begin
      if (kind == pcs_tx_pkg::KIND_T)
        next = ST_T;
      else if (kind == pcs_tx_pkg::KIND_D)
        next = ST_D;
      else if (kind == pcs_tx_pkg::KIND_C)
        next = ST_C;
    end
    else if (kind == pcs_tx_pkg::KIND_C)
      next = ST_C;
    else if (kind == pcs_tx_pkg::KIND_S)
      next = ST_D;
    seq_state = next;
    if (next == ST_E)
    begin
      exp_errcnt++;
      return ERR_BLOCK;
    end
    return blk;
  endfunction

  function automatic logic [65:0] scramble_ref(input logic [65:0] blk);
    logic [65:0] res;
    logic        b;
    res = blk;
    if (!cur_bypass)
    begin
      for (int i = 2; i < 66; i++)
      begin
        b         = blk[i] ^ scr_state[38] ^ scr_state[57];
        res[i]    = b;
        scr_state = {scr_state[56:0], b};
      end
    end
    return res;
  endfunction

  // Expected blocks queued on input transfers and checked on output transfers
  always @(posedge i_clock)
  begin
    if (!i_reset && i_xg_valid && o_xg_ready)
    begin
      ref_kind = encode_ref(i_xg, ref_blk);
      ref_blk  = check_ref(ref_kind, ref_blk);
      exp_q.push_back(scramble_ref(ref_blk));
      accepted_count++;
    end
    if (!i_reset && o_block_valid && i_block_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Unexpected output block at time %0t while none was pending", $time);
        stop_run();
      end
      else
      begin
        exp_blk = exp_q.pop_front();
        check_value(o_block, exp_blk, "output block");
        out_count++;
      end
    end
  end

  always @(negedge i_clock)
    i_block_ready = ready_random ? (($random(seed) & 3) != 0) : 1'b1;

  initial
  begin
    #(CLK_PERIOD * (50 * N_WORDS + 1000));
    $display("Timeout: the run did not finish within %0d cycles", 50 * N_WORDS + 1000);
    stop_run();
  end

  function automatic pcs_tx_pkg::xgmii_word_t make_word(input logic [63:0] d,
                                                        input logic [7:0] c);
    pcs_tx_pkg::xgmii_word_t w;
    w.data = d;
    w.ctrl = c;
    return w;
  endfunction

  task automatic send_word(input pcs_tx_pkg::xgmii_word_t xg);
    int taken;
    int gap;
    taken = accepted_count;
    sent_count++;
    if (gaps_on && (($random(seed) & 3) == 0))
    begin
      gap        = 1 + (($random(seed) & 32'h7fffffff) % 3);
      i_xg_valid = 1'b0;
      repeat (gap) @(negedge i_clock);
    end
    i_xg       = xg;
    i_xg_valid = 1'b1;
    do
      @(negedge i_clock);
    while (accepted_count == taken);
    i_xg_valid = 1'b0;
  endtask

  task automatic send_idle();
    send_word(make_word({8{`PCS_XG_IDLE}}, 8'hFF));
  endtask

  task automatic send_data();
    send_word(make_word({$random(seed), $random(seed)}, 8'h00));
  endtask

  task automatic send_start();
    logic [63:0] d;
    d      = {$random(seed), $random(seed)};
    d[7:0] = `PCS_XG_START;
    send_word(make_word(d, 8'h01));
  endtask

  task automatic send_frame(input int lane, input int ndata);
    logic [63:0] d;
    send_start();
    repeat (ndata) send_data();
    d = {$random(seed), $random(seed)};
    d[8*lane +: 8] = `PCS_XG_TERM;
    for (int j = lane + 1; j < 8; j++)
      d[8*j +: 8] = `PCS_XG_IDLE;
    send_word(make_word(d, 8'hFF << lane));
  endtask

  task automatic reg_write(input logic addr, input logic [31:0] data);
    @(negedge i_clock);
    i_reg_wr    = 1'b1;
    i_reg_addr  = addr;
    i_reg_wdata = data;
    @(negedge i_clock);
    i_reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic addr, output logic [31:0] data);
    @(negedge i_clock);
    i_reg_rd   = 1'b1;
    i_reg_addr = addr;
    @(negedge i_clock);
    i_reg_rd = 1'b0;
    data     = o_reg_rdata;
  endtask

  task automatic set_ctrl(input logic enable, input logic bypass);
    reg_write(`PCS_REG_CTRL, {30'd0, bypass, enable});
    cur_bypass = bypass;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge i_clock);
    repeat (2) @(negedge i_clock);
  endtask

  initial
  begin
    i_reset     = 1'b1;
    i_xg        = '0;
    i_xg_valid  = 1'b0;
    i_reg_wr    = 1'b0;
    i_reg_rd    = 1'b0;
    i_reg_addr  = 1'b0;
    i_reg_wdata = '0;
    repeat (8) @(posedge i_clock);
    @(negedge i_clock);
    i_reset = 1'b0;

    set_ctrl(1'b1, 1'b1); // Plain blocks first
    repeat (2) send_idle();
    for (int k = 0; k < 8; k++)
    begin
      send_frame(k, 2);
      send_idle();
    end
    wait_drain();

    set_ctrl(1'b1, 1'b0);
    repeat (2) send_idle();
    for (int k = 0; k < 8; k++)
    begin
      send_frame(k, 2);
      send_idle();
    end
    wait_drain();

    // Illegal sequences and bad words
    send_idle();
    send_data();
    send_start();
    send_idle();
    send_start();
    send_data();
    send_word(make_word({24'h123456, `PCS_XG_ERROR, 32'h9abcdef0}, 8'h10));
    send_frame(3, 0);
    send_idle();
    send_word(make_word({{7{`PCS_XG_IDLE}}, 8'h55}, 8'h01));
    send_idle();
    wait_drain();
    reg_read(`PCS_REG_ERRCNT, rdata);
    check_value(rdata, exp_errcnt, "error count");
    reg_write(`PCS_REG_ERRCNT, 32'd0);
    exp_errcnt = 0;
    reg_read(`PCS_REG_ERRCNT, rdata);
    check_value(rdata, 0, "error count after clear");

    gaps_on      = 1'b1;
    ready_random = 1'b1;
    for (int f = 0; f < 16; f++)
    begin
      send_idle();
      send_frame(($random(seed) & 32'h7fffffff) % 8, ($random(seed) & 32'h7fffffff) % 3);
    end
    wait_drain();
    gaps_on      = 1'b0;
    ready_random = 1'b0;

    set_ctrl(1'b0, 1'b1);
    reg_read(`PCS_REG_CTRL, rdata);
    check_value(rdata, 32'd2, "CTRL readback");
    i_xg       = make_word({8{`PCS_XG_IDLE}}, 8'hFF);
    i_xg_valid = 1'b1;
    repeat (20)
    begin
      @(negedge i_clock);
      check_value(o_xg_ready, 1'b0, "input ready while disabled");
    end
    i_xg_valid = 1'b0;
    repeat (10) @(negedge i_clock);
    check_value(out_count, sent_count, "output block count");

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== pcs_tx.f ====
+incdir+src
src/pcs_tx_pkg.sv
src/pcs_tx_block_encoder.sv
src/pcs_tx_sequence_check.sv
src/pcs_tx_scrambler.sv
src/pcs_tx_regs.sv
src/pcs_tx.sv
bench/pcs_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pcs_tx_tb
FILELIST  ?= pcs_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard src/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BUILD_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(BUILD_DIR) -o V$*

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
